// File: logic/spritePkg.sv
package spritePkg;

    // --------------------------------------------------
    // dot memory contents
    // --------------------------------------------------
    typedef logic [11:0] dotT;       // 4:4:4 rgb
    typedef logic [9:0]  dotAddrT;   // four chips of 16x16
    typedef logic [3:0]  chipOffT;   // row or column inside a chip

    localparam dotT DOT_CLEAR = '0;  // transparent key

    // memory map, each chip row-major and drawn facing left
    localparam dotAddrT TILE_BASE   = 10'd0;    // tile chips 0,1
    localparam dotAddrT PLAYER_BASE = 10'd512;  // walk frames 0,1

    // --------------------------------------------------
    // player control
    // --------------------------------------------------
    typedef enum logic
    {
        FACE_LEFT,
        FACE_RIGHT
    } facingT;

    // movement command from the host, 2 bits
    typedef enum logic [1:0]
    {
        DIR_IDLE,
        DIR_LEFT,
        DIR_RIGHT
    } dirT;

    // host write into the dot memory, no handshake
    typedef struct packed
    {
        logic    we;
        dotAddrT addr;
        dotT     dot;
    } dotLoadT;

endpackage

// File: logic/dispPkg.sv
package dispPkg;

    // output dot carries a colour from the sprite side
    import spritePkg::*;

    // --------------------------------------------------
    // raster position
    // --------------------------------------------------
    typedef logic [9:0] hPosT;    // screen column
    typedef logic [9:0] vPosT;    // screen row

    // one scan beat, raster order
    typedef struct packed
    {
        hPosT hPos;
        vPosT vPos;
    } scanBeatT;

    // --------------------------------------------------
    // output dot
    // --------------------------------------------------
    // position of the beat plus its final colour, 32 bits
    typedef struct packed
    {
        scanBeatT pos;
        dotT      dot;
    } dotOutT;

endpackage

// File: logic/dotStore.sv
`timescale 1ns/1ns

module dotStore
    import spritePkg::*;
(
    input  logic    iCLK,
    input  dotLoadT iLoad,
    input  logic    iRdEn,
    input  dotAddrT iRdAddr,
    output dotT     oRdData
);

localparam int DEPTH = 2 ** $bits(dotAddrT);   // 1024 words

dotT mem [DEPTH];

// host port writes, arbiter port reads
always_ff @(posedge iCLK)
begin
    if (iLoad.we)
    begin
        mem[iLoad.addr] <= iLoad.dot;
    end
    if (iRdEn)
    begin
        oRdData <= mem[iRdAddr];   // valid the cycle after the strobe
    end
end

endmodule

// File: logic/dotArbiter.sv
`timescale 1ns/1ns

module dotArbiter
    import spritePkg::*;
(
    input  logic    iCLK,
    input  logic    iRST,
    input  logic    iTileReqValid,
    output logic    oTileReqReady,
    input  dotAddrT iTileReqAddr,
    input  logic    iPlayerReqValid,
    output logic    oPlayerReqReady,
    input  dotAddrT iPlayerReqAddr,
    output logic    oRdEn,
    output dotAddrT oRdAddr,
    input  dotT     iRdData,
    output logic    oTileRdValid,
    output logic    oPlayerRdValid,
    output dotT     oRdData
);

logic tileTurn;      // tile wins the next tie
logic grantTile, grantPlayer;
logic rdPend;        // memory word comes back this cycle
logic ownerTile;     // owner tag of that word

// --------------------------------------------------
// round-robin grant, one read per cycle
// --------------------------------------------------
assign grantTile   = iTileReqValid && (!iPlayerReqValid || tileTurn);
assign grantPlayer = iPlayerReqValid && (!iTileReqValid || !tileTurn);

assign oTileReqReady   = grantTile;
assign oPlayerReqReady = grantPlayer;
assign oRdEn           = grantTile || grantPlayer;
assign oRdAddr         = grantTile ? iTileReqAddr : iPlayerReqAddr;

always_ff @(posedge iCLK)
begin
    if (iRST)
    begin
        tileTurn  <= 1'b1;
        rdPend    <= 1'b0;
        ownerTile <= 1'b0;
    end
    else
    begin
        rdPend <= oRdEn;
        if (grantTile)
        begin
            tileTurn  <= 1'b0;   // player next
            ownerTile <= 1'b1;
        end
        else if (grantPlayer)
        begin
            tileTurn  <= 1'b1;
            ownerTile <= 1'b0;
        end
    end
end

// --------------------------------------------------
// return path, steered by the tag
// --------------------------------------------------
assign oTileRdValid   = rdPend && ownerTile;
assign oPlayerRdValid = rdPend && !ownerTile;
assign oRdData        = iRdData;

endmodule

// File: logic/tileDotAddr.sv
`timescale 1ns/1ns

module tileDotAddr
    import dispPkg::*;
    import spritePkg::*;
#(
    parameter int H_ACTIVE = 640,
    parameter int V_ACTIVE = 480
)(
    input  logic     iCLK,
    input  logic     iRST,
    input  logic     iBeatValid,
    output logic     oBeatReady,
    input  scanBeatT iBeat,
    output logic     oReqValid,
    input  logic     iReqReady,
    output dotAddrT  oReqAddr,
    input  logic     iRdValid,
    input  dotT      iRdData,
    output logic     oResValid,
    input  logic     iResReady,
    output dotT      oResDot
);

typedef enum logic [1:0] {IDLE, FETCH, WAIT, DONE} stateT;

stateT    state;
scanBeatT beat;
dotT      resDot;
logic     beatFire, onScreen, chipSel;

assign beatFire = iBeatValid && oBeatReady;
assign onScreen = (iBeat.hPos < hPosT'(H_ACTIVE)) && (iBeat.vPos < vPosT'(V_ACTIVE));

always_ff @(posedge iCLK)
begin
    if (iRST)
    begin
        state <= IDLE;
    end
    else
    begin
        case (state)
            IDLE:  if (beatFire)  state <= onScreen ? FETCH : DONE;  // blank border, no read
            FETCH: if (iReqReady) state <= WAIT;
            WAIT:  if (iRdValid)  state <= DONE;
            DONE:  if (iResReady) state <= IDLE;
        endcase
    end
end

always_ff @(posedge iCLK)
begin
    if (beatFire)
    begin
        beat   <= iBeat;
        resDot <= DOT_CLEAR;
    end
    if ((state == WAIT) && iRdValid)
    begin
        resDot <= iRdData;
    end
end

// checkerboard, chip flips every 16 dots in both directions
assign chipSel  = beat.hPos[4] ^ beat.vPos[4];
assign oReqAddr = TILE_BASE + {1'b0, chipSel, beat.vPos[3:0], beat.hPos[3:0]};

assign oBeatReady = (state == IDLE);
assign oReqValid  = (state == FETCH);
assign oResValid  = (state == DONE);   // tile always hits
assign oResDot    = resDot;

endmodule

// File: logic/playerDotAddr.sv
`timescale 1ns/1ns

module playerDotAddr
    import dispPkg::*;
    import spritePkg::*;
#(
    parameter int H_ACTIVE    = 640,
    parameter int V_ACTIVE    = 480,
    parameter int ANIM_FRAMES = 8
)(
    input  logic     iCLK,
    input  logic     iRST,
    input  logic     iBeatValid,
    output logic     oBeatReady,
    input  scanBeatT iBeat,
    input  hPosT     iBoxXS,
    input  hPosT     iBoxXE,
    input  vPosT     iBoxYS,
    input  vPosT     iBoxYE,
    input  dirT      iDir,
    output logic     oReqValid,
    input  logic     iReqReady,
    output dotAddrT  oReqAddr,
    input  logic     iRdValid,
    input  dotT      iRdData,
    output logic     oResValid,
    input  logic     iResReady,
    output dotT      oResDot,
    output logic     oResHit
);

localparam int CNT_W = $clog2(ANIM_FRAMES + 1);

typedef enum logic [1:0] {IDLE, FETCH, WAIT, DONE} stateT;

stateT            state;
scanBeatT         beat;           // beat held until its result leaves
hPosT             boxXS, boxXE;
vPosT             boxYS, boxYE;
hPosT             xs, xe;         // box in effect for the incoming beat
vPosT             ys, ye;
facingT           facing;
logic             walkFrame;
logic [CNT_W-1:0] frameCnt;
logic             beatFire, frameStart, moving, inBox;
chipOffT          rowOff, colRaw, colOff;
dotT              resDot;
logic             resHit;

assign beatFire   = iBeatValid && oBeatReady;
assign frameStart = (iBeat.hPos == '0) && (iBeat.vPos == '0);
assign moving     = iDir inside {DIR_LEFT, DIR_RIGHT};

// a frame-start beat already sees the new box
assign xs = frameStart ? iBoxXS : boxXS;
assign xe = frameStart ? iBoxXE : boxXE;
assign ys = frameStart ? iBoxYS : boxYS;
assign ye = frameStart ? iBoxYE : boxYE;

assign inBox = (iBeat.hPos >= xs) && (iBeat.hPos < xe)
            && (iBeat.vPos >= ys) && (iBeat.vPos < ye)
            && (iBeat.hPos < hPosT'(H_ACTIVE))     // clip at screen edge
            && (iBeat.vPos < vPosT'(V_ACTIVE));

// --------------------------------------------------
// per-frame state, facing and walk animation
// --------------------------------------------------
always_ff @(posedge iCLK)
begin
    if (iRST)
    begin
        facing    <= FACE_RIGHT;
        walkFrame <= 1'b0;
        frameCnt  <= '0;
    end
    else if (beatFire && frameStart)
    begin
        case (iDir)
            DIR_LEFT:  facing <= FACE_LEFT;
            DIR_RIGHT: facing <= FACE_RIGHT;
            default:   facing <= facing;     // idle keeps last facing
        endcase
        if (moving)
        begin
            if (frameCnt == CNT_W'(ANIM_FRAMES - 1))
            begin
                walkFrame <= ~walkFrame;     // next walk step
                frameCnt  <= '0;
            end
            else
            begin
                frameCnt <= frameCnt + 1'b1;
            end
        end
    end
end

// box holds for the whole frame
always_ff @(posedge iCLK)
begin
    if (beatFire && frameStart)
    begin
        boxXS <= iBoxXS;
        boxXE <= iBoxXE;
        boxYS <= iBoxYS;
        boxYE <= iBoxYE;
    end
end

// --------------------------------------------------
// fetch FSM
// --------------------------------------------------
always_ff @(posedge iCLK)
begin
    if (iRST)
    begin
        state <= IDLE;
    end
    else
    begin
        case (state)
            IDLE:  if (beatFire)  state <= inBox ? FETCH : DONE;  // miss skips the read
            FETCH: if (iReqReady) state <= WAIT;
            WAIT:  if (iRdValid)  state <= DONE;
            DONE:  if (iResReady) state <= IDLE;
        endcase
    end
end

always_ff @(posedge iCLK)
begin
    if (beatFire)
    begin
        beat   <= iBeat;
        resHit <= inBox;
        resDot <= DOT_CLEAR;
    end
    if ((state == WAIT) && iRdValid)
    begin
        resDot <= iRdData;   // word from the arbiter
    end
end

// offsets wrap inside one chip
assign rowOff = chipOffT'(beat.vPos - boxYS);
assign colRaw = chipOffT'(beat.hPos - boxXS);
assign colOff = (facing == FACE_RIGHT) ? ~colRaw : colRaw;  // 15 - x when mirrored

assign oReqAddr   = PLAYER_BASE + {1'b0, walkFrame, rowOff, colOff};
assign oBeatReady = (state == IDLE);
assign oReqValid  = (state == FETCH);
assign oResValid  = (state == DONE);
assign oResDot    = resDot;
assign oResHit    = resHit;

endmodule

// File: logic/dotCompositor.sv
`timescale 1ns/1ns

module dotCompositor
    import dispPkg::*;
    import spritePkg::*;
(
    input  logic     iCLK,
    input  logic     iRST,
    input  logic     iScanValid,
    output logic     oScanReady,
    input  scanBeatT iScan,
    output logic     oBeatValid,
    input  logic     iTileBeatReady,
    input  logic     iPlayerBeatReady,
    output scanBeatT oBeat,
    input  logic     iTileResValid,
    output logic     oTileResReady,
    input  dotT      iTileDot,
    input  logic     iPlayerResValid,
    output logic     oPlayerResReady,
    input  dotT      iPlayerDot,
    input  logic     iPlayerHit,
    output logic     oDotValid,
    input  logic     iDotReady,
    output dotOutT   oDot
);

scanBeatT   posFifo [2];    // positions of beats inside the generators
logic       wrPtr, rdPtr;
logic [1:0] fill;
logic       room, scanFire, outFree, resJoin;
logic       outValid;
dotOutT     outDot;
dotT        mergedDot;

// --------------------------------------------------
// fork, beat passes only when both sides take it
// --------------------------------------------------
assign room       = (fill != 2'd2);
assign oScanReady = iTileBeatReady && iPlayerBeatReady && room;
assign scanFire   = iScanValid && oScanReady;
assign oBeatValid = scanFire;
assign oBeat      = iScan;

// --------------------------------------------------
// join and transparency merge
// --------------------------------------------------
assign outFree         = !outValid || iDotReady;
assign resJoin         = iTileResValid && iPlayerResValid && outFree;
assign oTileResReady   = resJoin;
assign oPlayerResReady = resJoin;
assign mergedDot = (iPlayerHit && (iPlayerDot != DOT_CLEAR)) ? iPlayerDot : iTileDot;

always_ff @(posedge iCLK)
begin
    if (iRST)
    begin
        wrPtr <= 1'b0;
        rdPtr <= 1'b0;
        fill  <= 2'd0;
    end
    else
    begin
        if (scanFire) wrPtr <= ~wrPtr;
        if (resJoin)  rdPtr <= ~rdPtr;
        fill <= fill + 2'(scanFire) - 2'(resJoin);
    end
end

always_ff @(posedge iCLK)
begin
    if (scanFire)
    begin
        posFifo[wrPtr] <= iScan;
    end
    if (resJoin)
    begin
        outDot <= '{pos: posFifo[rdPtr], dot: mergedDot};
    end
end

// output register, holds under back-pressure
always_ff @(posedge iCLK)
begin
    if (iRST)            outValid <= 1'b0;
    else if (resJoin)    outValid <= 1'b1;
    else if (iDotReady)  outValid <= 1'b0;
end

assign oDotValid = outValid;
assign oDot      = outDot;

endmodule

// File: logic/spriteRenderTop.sv
`timescale 1ns/1ns

module spriteRenderTop
    import dispPkg::*;
    import spritePkg::*;
#(
    parameter int H_ACTIVE    = 640,
    parameter int V_ACTIVE    = 480,
    parameter int ANIM_FRAMES = 8
)(
    input  logic     iCLK,
    input  logic     iRST,
    input  logic     iScanValid,
    output logic     oScanReady,
    input  scanBeatT iScan,
    input  hPosT     iBoxXS,
    input  hPosT     iBoxXE,
    input  vPosT     iBoxYS,
    input  vPosT     iBoxYE,
    input  dirT      iDir,
    input  dotLoadT  iLoad,
    output logic     oDotValid,
    input  logic     iDotReady,
    output dotOutT   oDot
);

// --------------------------------------------------
// internal wiring
// --------------------------------------------------
logic     beatValid, tileBeatReady, playerBeatReady;
scanBeatT beat;
logic     tileResValid, tileResReady, playerResValid, playerResReady, playerHit;
dotT      tileDot, playerDot;
logic     tileReqValid, tileReqReady, playerReqValid, playerReqReady;
dotAddrT  tileReqAddr, playerReqAddr, rdAddr;
logic     rdEn, tileRdValid, playerRdValid;
dotT      storeData, rdData;

dotCompositor i_compositor (
    .iCLK(iCLK), .iRST(iRST),
    .iScanValid(iScanValid), .oScanReady(oScanReady), .iScan(iScan),
    .oBeatValid(beatValid), .iTileBeatReady(tileBeatReady),
    .iPlayerBeatReady(playerBeatReady), .oBeat(beat),
    .iTileResValid(tileResValid), .oTileResReady(tileResReady), .iTileDot(tileDot),
    .iPlayerResValid(playerResValid), .oPlayerResReady(playerResReady),
    .iPlayerDot(playerDot), .iPlayerHit(playerHit),
    .oDotValid(oDotValid), .iDotReady(iDotReady), .oDot(oDot)
);

tileDotAddr #(.H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE)) i_tile (
    .iCLK(iCLK), .iRST(iRST),
    .iBeatValid(beatValid), .oBeatReady(tileBeatReady), .iBeat(beat),
    .oReqValid(tileReqValid), .iReqReady(tileReqReady), .oReqAddr(tileReqAddr),
    .iRdValid(tileRdValid), .iRdData(rdData),
    .oResValid(tileResValid), .iResReady(tileResReady), .oResDot(tileDot)
);

playerDotAddr #(
    .H_ACTIVE(H_ACTIVE), .V_ACTIVE(V_ACTIVE), .ANIM_FRAMES(ANIM_FRAMES)
) i_player (
    .iCLK(iCLK), .iRST(iRST),
    .iBeatValid(beatValid), .oBeatReady(playerBeatReady), .iBeat(beat),
    .iBoxXS(iBoxXS), .iBoxXE(iBoxXE), .iBoxYS(iBoxYS), .iBoxYE(iBoxYE), .iDir(iDir),
    .oReqValid(playerReqValid), .iReqReady(playerReqReady), .oReqAddr(playerReqAddr),
    .iRdValid(playerRdValid), .iRdData(rdData),
    .oResValid(playerResValid), .iResReady(playerResReady),
    .oResDot(playerDot), .oResHit(playerHit)
);

dotArbiter i_arbiter (
    .iCLK(iCLK), .iRST(iRST),
    .iTileReqValid(tileReqValid), .oTileReqReady(tileReqReady),
    .iTileReqAddr(tileReqAddr),
    .iPlayerReqValid(playerReqValid), .oPlayerReqReady(playerReqReady),
    .iPlayerReqAddr(playerReqAddr),
    .oRdEn(rdEn), .oRdAddr(rdAddr), .iRdData(storeData),
    .oTileRdValid(tileRdValid), .oPlayerRdValid(playerRdValid), .oRdData(rdData)
);

dotStore i_store (
    .iCLK(iCLK), .iLoad(iLoad),
    .iRdEn(rdEn), .iRdAddr(rdAddr), .oRdData(storeData)
);

endmodule

// File: verification/spriteRenderTb.sv
`timescale 1ns/1ns

module spriteRenderTb
    import dispPkg::*;
    import spritePkg::*;
();

localparam int H = 64;                        // small screen for simulation
localparam int V = 48;
localparam int ANIM = 2;                      // frames per walk step
localparam int FRAME_BEATS = H * V;
localparam int TOTAL_BEATS = 15 * FRAME_BEATS + 1500;   // 15 full frames and a partial one
localparam int CYCLE_LIMIT = TOTAL_BEATS * 6 + 2000;

logic     iCLK = 1'b0;
logic     iRST, iScanValid, oScanReady, oDotValid, iDotReady;
scanBeatT iScan;
hPosT     iBoxXS, iBoxXE;
vPosT     iBoxYS, iBoxYE;
dirT      iDir;
dotLoadT  iLoad;
dotOutT   oDot;

dotT      memModel [1024];   // copy of the dot memory
dotOutT   expQ [$];          // expected dots in output order
dotOutT   expHead;
facingT   mFacing;
logic     mFrame;
int       mCnt;
hPosT     mXS, mXE;
vPosT     mYS, mYE;
logic     bpOn;              // random iDotReady when set
int       errors, errStart, passCnt, failCnt, cycles, seedVal;

spriteRenderTop #(.H_ACTIVE(H), .V_ACTIVE(V), .ANIM_FRAMES(ANIM)) i_dut (
    .iCLK(iCLK), .iRST(iRST),
    .iScanValid(iScanValid), .oScanReady(oScanReady), .iScan(iScan),
    .iBoxXS(iBoxXS), .iBoxXE(iBoxXE), .iBoxYS(iBoxYS), .iBoxYE(iBoxYE), .iDir(iDir),
    .iLoad(iLoad),
    .oDotValid(oDotValid), .iDotReady(iDotReady), .oDot(oDot)
);

always #4 iCLK = ~iCLK;   // 8 ns period

// cycle limit
always @(posedge iCLK)
begin
    cycles++;
    if (cycles >= CYCLE_LIMIT)
    begin
        $display("run stopped at the cycle limit with %0d dots still pending", expQ.size());
        $display("FAIL: see errors above");
        $finish;
    end
end

// --------------------------------------------------
// output monitor
// --------------------------------------------------
always @(posedge iCLK)
begin
    if (!iRST && oDotValid && iDotReady)
    begin
        if (expQ.size() == 0)
        begin
            $display("an output dot came out at %0t with no beat waiting for it", $time);
            errors++;
        end
        else
        begin
            expHead = expQ.pop_front();
            if (oDot !== expHead)
            begin
                $display("FAILED %0t: dot %h at (%0d,%0d), expected %h at (%0d,%0d)", $time,
                         oDot.dot, oDot.pos.hPos, oDot.pos.vPos,
                         expHead.dot, expHead.pos.hPos, expHead.pos.vPos);
                errors++;
            end
        end
    end
end

// --------------------------------------------------
// reference model
// --------------------------------------------------
function automatic dotT tileColour(hPosT h, vPosT v);
    int chip, addr;
    chip = (int'(h) / 16 + int'(v) / 16) % 2;          // checkerboard
    addr = chip * 256 + (int'(v) % 16) * 16 + int'(h) % 16;
    return memModel[addr];
endfunction

// latches box and direction at frame start
function automatic void latchFrame();
    mXS = iBoxXS;
    mXE = iBoxXE;
    mYS = iBoxYS;
    mYE = iBoxYE;
    if (iDir == DIR_LEFT)
        mFacing = FACE_LEFT;
    else if (iDir == DIR_RIGHT)
        mFacing = FACE_RIGHT;
    if (iDir != DIR_IDLE)
    begin
        mCnt++;
        if (mCnt == ANIM)
        begin
            mFrame = !mFrame;   // next walk step
            mCnt   = 0;
        end
    end
endfunction

function automatic dotOutT expectedDot(hPosT h, vPosT v);
    dotOutT res;
    dotT    pDot;
    logic   hit;
    int     col, row, addr;
    hit  = (h >= mXS) && (h < mXE) && (v >= mYS) && (v < mYE);
    pDot = '0;
    if (hit)
    begin
        col = (int'(h) - int'(mXS)) % 16;
        row = (int'(v) - int'(mYS)) % 16;
        if (mFacing == FACE_RIGHT)
            col = 15 - col;                           // chips are drawn facing left
        addr = 512 + (mFrame ? 256 : 0) + row * 16 + col;
        pDot = memModel[addr];
    end
    res.pos.hPos = h;
    res.pos.vPos = v;
    res.dot      = (hit && pDot != '0) ? pDot : tileColour(h, v);
    return res;
endfunction

// --------------------------------------------------
// stimulus
// --------------------------------------------------
task automatic stepCycle(output logic taken);
    @(posedge iCLK);
    taken = iScanValid && oScanReady;
    #1;
    iDotReady = !bpOn || ($urandom % 2 == 1);
endtask

task automatic sendBeat(hPosT h, vPosT v);
    logic taken;
    while ($urandom % 8 == 0)   // random valid gap
    begin
        iScanValid = 1'b0;
        stepCycle(taken);
    end
    if (h == '0 && v == '0)
        latchFrame();
    expQ.push_back(expectedDot(h, v));
    iScan.hPos = h;
    iScan.vPos = v;
    iScanValid = 1'b1;
    do
        stepCycle(taken);
    while (!taken);
    iScanValid = 1'b0;
endtask

// raster order and possibly cut short
task automatic sendFrame(int beats);
    int n;
    n = 0;
    for (int v = 0; v < V; v++)
    begin
        for (int h = 0; h < H; h++)
        begin
            if (n < beats)
                sendBeat(hPosT'(h), vPosT'(v));
            n++;
        end
    end
endtask

task automatic runFrames(int frames, dirT d);
    iDir = d;
    repeat (frames) sendFrame(FRAME_BEATS);
endtask

task automatic setBox(int xs, int xe, int ys, int ye);
    iBoxXS = hPosT'(xs);
    iBoxXE = hPosT'(xe);
    iBoxYS = vPosT'(ys);
    iBoxYE = vPosT'(ye);
endtask

task automatic applyReset();
    logic taken;
    iScanValid = 1'b0;
    iRST       = 1'b1;
    expQ.delete();   // beats in flight are dropped by the DUT
    repeat (4) stepCycle(taken);
    iRST    = 1'b0;
    mFacing = FACE_RIGHT;
    mFrame  = 1'b0;
    mCnt    = 0;
endtask

task automatic loadMemory();
    logic taken;
    dotT  d;
    for (int a = 0; a < 1024; a++)
    begin
        d = ($urandom % 4 == 0) ? dotT'(0) : dotT'(1 + $urandom % 4095);  // ~1/4 clear
        memModel[a] = d;
        iLoad.we   = 1'b1;
        iLoad.addr = dotAddrT'(a);
        iLoad.dot  = d;
        stepCycle(taken);
    end
    iLoad = '0;
endtask

// waits for the queue to empty and reports missing dots
task automatic drainDots();
    logic taken;
    int   idle;
    idle = 0;
    while (expQ.size() != 0 && idle < 200)
    begin
        stepCycle(taken);
        idle++;
    end
    if (expQ.size() != 0)
    begin
        $display("%0d expected dots never came out by %0t", expQ.size(), $time);
        errors += expQ.size();
        expQ.delete();
    end
endtask

task automatic finishTest(string name);
    if (errors == errStart)
    begin
        passCnt++;
        $display("test %s: ok", name);
    end
    else
    begin
        failCnt++;
        $display("test %s: %0d errors", name, errors - errStart);
    end
    errStart = errors;
endtask

// --------------------------------------------------
// test sequence
// --------------------------------------------------
initial
begin
    seedVal    = $urandom(32'h2ce5);
    iRST       = 1'b1;
    iScanValid = 1'b0;
    iScan      = '0;
    iDir       = DIR_IDLE;
    iLoad      = '0;
    iDotReady  = 1'b1;
    bpOn       = 1'b0;
    setBox(0, 0, 0, 0);
    applyReset();
    loadMemory();

    setBox(10, 42, 8, 40);
    runFrames(1, DIR_RIGHT);
    drainDots();
    finishTest("1 facing right, mirrored player over checkerboard");

    setBox(5, 21, 20, 36);
    runFrames(1, DIR_LEFT);
    runFrames(1, DIR_IDLE);      // facing stays left
    drainDots();
    finishTest("2 facing left, held through idle");

    setBox(30, 46, 12, 28);
    runFrames(3, DIR_RIGHT);
    runFrames(2, DIR_IDLE);      // frame and counter hold
    runFrames(3, DIR_LEFT);
    drainDots();
    finishTest("3 walk animation");

    bpOn = 1'b1;
    setBox(20, 52, 16, 48);
    runFrames(1, DIR_RIGHT);
    drainDots();
    bpOn = 1'b0;
    finishTest("4 output back-pressure");

    setBox(48, 64, 36, 48);      // lower right corner
    runFrames(1, DIR_LEFT);
    setBox(20, 20, 10, 30);      // empty box
    runFrames(1, DIR_IDLE);
    drainDots();
    finishTest("5 edge box and empty box");

    setBox(8, 24, 8, 24);
    iDir = DIR_LEFT;
    sendFrame(1500);             // walk frame 1 and facing left here
    applyReset();                // mid-frame
    runFrames(1, DIR_IDLE);      // back to facing right and frame 0
    drainDots();
    finishTest("6 reset in mid-frame");

    $display("tests passed: %0d, failed: %0d", passCnt, failCnt);
    if (failCnt == 0 && errors == 0)
        $display("PASS: all tests");
    else
        $display("FAIL: see errors above");
    $finish;
end

endmodule

// File: spriteRenderTop.f
logic/spritePkg.sv
logic/dispPkg.sv
logic/dotStore.sv
logic/dotArbiter.sv
logic/tileDotAddr.sv
logic/playerDotAddr.sv
logic/dotCompositor.sv
logic/spriteRenderTop.sv
verification/spriteRenderTb.sv

// File: Bender.yml
package:
  name: sprite_render

sources:
  - logic/spritePkg.sv
  - logic/dispPkg.sv
  - logic/dotStore.sv
  - logic/dotArbiter.sv
  - logic/tileDotAddr.sv
  - logic/playerDotAddr.sv
  - logic/dotCompositor.sv
  - logic/spriteRenderTop.sv
  - target: simulation
    files:
      - verification/spriteRenderTb.sv
